/* verilog/ghtPkg.sv */
////////////////////////////////////////////////////////////
// shared types and geometry for the global-history
// direction table: index union, training request and
// per-bank read and write structs
////////////////////////////////////////////////////////////

`default_nettype none

package ghtPkg;

    // table geometry
    localparam int numBanks = 8;
    localparam int numRows  = 32;
    localparam int rowBits  = 256;
    localparam int numSlots = 4;
    localparam int bankBits = 3;
    localparam int slotBits = 2;

    // field view of a table index
    // bank number is {bankHi, bankLo}
    typedef struct packed {
        logic [7:0] bitSel;
        logic [1:0] bankHi;
        logic [4:0] row;
        logic       bankLo;
    } ghtIndexFields_t;

    typedef union packed {
        logic [15:0]     word;
        ghtIndexFields_t fields;
    } ghtIndex_u;

    // one training update
    typedef struct packed {
        logic      valid;
        ghtIndex_u index;
        logic      taken;
    } ghtWrite_t;

    // write into one bank, clear zeros the whole row
    typedef struct packed {
        logic       en;
        logic       clear;
        logic [4:0] row;
        logic [7:0] bitSel;
    } ghtBankWrite_t;

    typedef struct packed {
        logic [4:0] row;
        logic [7:0] bitSel;
    } ghtBankRead_t;

endpackage

`default_nettype wire

/* verilog/ghtLookup.sv */
////////////////////////////////////////////////////////////
// lookup input registers and per-slot address generation
// slot k reads bank {bankHi^k, bankLo} with history shifted
// by the number of jump slots below it
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ghtLookup (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        readEn,
    input  logic [15:0]                 ipBits,
    input  logic [15:0]                 history,
    input  logic [3:0]                  jumpMask,
    output ghtPkg::ghtBankRead_t        bankRead [ghtPkg::numBanks],
    output logic [ghtPkg::bankBits-1:0] slotBank [ghtPkg::numSlots],
    output logic [3:0]                  jumpMaskReg
);

    import ghtPkg::*;

    logic [15:0] ipBitsReg;
    logic [15:0] historyReg;
    ghtIndex_u   baseIdx;
    logic [7:0]  slotBitSel [numSlots];

    // jump mask is the only control state, clearing it masks all slots
    always_ff @(posedge clk) begin
        if (rst) begin
            jumpMaskReg <= '0;
        end else if (readEn) begin
            jumpMaskReg <= jumpMask;
        end
    end

    always_ff @(posedge clk) begin
        if (readEn) begin
            ipBitsReg  <= ipBits;
            historyReg <= history;
        end
    end

    assign baseIdx.word = ipBitsReg ^ historyReg;

    always_comb begin
        logic [slotBits-1:0] jumpsBelow;
        jumpsBelow = '0;
        for (int k = 0; k < numSlots; k++) begin
            slotBitSel[k] = ipBitsReg[15:8] ^ (historyReg[15:8] << jumpsBelow);
            slotBank[k]   = {baseIdx.fields.bankHi ^ slotBits'(k), baseIdx.fields.bankLo};
            jumpsBelow    = jumpsBelow + slotBits'(jumpMaskReg[k]);
        end
    end

    // the xor on bankHi spreads the four slots over four distinct banks
    always_comb begin
        for (int b = 0; b < numBanks; b++) begin
            bankRead[b] = '0;
            for (int k = 0; k < numSlots; k++) begin
                if (slotBank[k] == bankBits'(b)) begin
                    bankRead[b].row    = baseIdx.fields.row;
                    bankRead[b].bitSel = slotBitSel[k];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/ghtBank.sv */
////////////////////////////////////////////////////////////
// one table bank: 32 rows of 256 direction bits
// single bit write or whole row clear, combinational read
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ghtBank (
    input  logic                  clk,
    input  ghtPkg::ghtBankWrite_t bankWrite,
    input  logic                  writeTaken,
    input  ghtPkg::ghtBankRead_t  bankRead,
    output logic                  readBit
);

    import ghtPkg::*;

    logic [rowBits-1:0] mem [numRows];

    always_ff @(posedge clk) begin
        if (bankWrite.en) begin
            if (bankWrite.clear) begin
                mem[bankWrite.row] <= '0;
            end else begin
                mem[bankWrite.row][bankWrite.bitSel] <= writeTaken;
            end
        end
    end

    // read straight from the array, so a write shows up in the next cycle
    assign readBit = mem[bankRead.row][bankRead.bitSel];

endmodule

`default_nettype wire

/* verilog/ghtWriteArbiter.sv */
////////////////////////////////////////////////////////////
// training write arbitration over the eight banks
// one-entry deferral register for same-bank conflicts
// and the post-reset row clear sequencer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ghtWriteArbiter (
    input  logic                         clk,
    input  logic                         rst,
    input  ghtPkg::ghtWrite_t            write0,
    input  ghtPkg::ghtWrite_t            write1,
    output ghtPkg::ghtBankWrite_t        bankWrite [ghtPkg::numBanks],
    output logic [ghtPkg::numBanks-1:0]  writeTaken
);

    import ghtPkg::*;

    ghtWrite_t                   deferred;
    logic                        clearing;
    logic [$clog2(numRows)-1:0]  clearCount;

    logic [bankBits-1:0] bank0;
    logic [bankBits-1:0] bank1;
    logic [bankBits-1:0] bankD;
    logic                v0;
    logic                v1;
    logic                conf0;
    logic                conf1;
    logic                go0;
    logic                go1;

    function automatic logic [bankBits-1:0] bankOf(ghtIndex_u idx);
        return {idx.fields.bankHi, idx.fields.bankLo};
    endfunction

    function automatic ghtBankWrite_t bitWrite(ghtIndex_u idx);
        ghtBankWrite_t w;
        w.en     = 1'b1;
        w.clear  = 1'b0;
        w.row    = idx.fields.row;
        w.bitSel = idx.fields.bitSel;
        return w;
    endfunction

    assign bank0 = bankOf(write0.index);
    assign bank1 = bankOf(write1.index);
    assign bankD = bankOf(deferred.index);

    // requests are dropped while the table is being cleared
    assign v0 = write0.valid & ~clearing;
    assign v1 = write1.valid & ~clearing;

    assign conf0 = deferred.valid & v0 & (bank0 == bankD);
    assign conf1 = v1 & ((deferred.valid & (bank1 == bankD)) | (v0 & (bank1 == bank0)));
    assign go0   = v0 & ~conf0;
    assign go1   = v1 & ~conf1;

    // write1 wins the deferral slot, write0 is lost if both conflict
    always_ff @(posedge clk) begin
        if (rst) begin
            deferred.valid <= 1'b0;
        end else if (conf1) begin
            deferred <= write1;
        end else if (conf0) begin
            deferred <= write0;
        end else begin
            deferred.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            clearing   <= 1'b1;
            clearCount <= '0;
        end else if (clearing) begin
            clearCount <= clearCount + 1'b1;
            if (clearCount == ($clog2(numRows))'(numRows - 1)) begin
                clearing <= 1'b0;
            end
        end
    end

    // deferred, write0 and write1 never share a bank once granted
    always_comb begin
        for (int b = 0; b < numBanks; b++) begin
            bankWrite[b]  = '0;
            writeTaken[b] = 1'b0;
            if (clearing) begin
                bankWrite[b].en    = 1'b1;
                bankWrite[b].clear = 1'b1;
                bankWrite[b].row   = clearCount;
            end else if (deferred.valid && bankD == bankBits'(b)) begin
                bankWrite[b]  = bitWrite(deferred.index);
                writeTaken[b] = deferred.taken;
            end else if (go0 && bank0 == bankBits'(b)) begin
                bankWrite[b]  = bitWrite(write0.index);
                writeTaken[b] = write0.taken;
            end else if (go1 && bank1 == bankBits'(b)) begin
                bankWrite[b]  = bitWrite(write1.index);
                writeTaken[b] = write1.taken;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/ghtSlotFilter.sv */
////////////////////////////////////////////////////////////
// per-slot selection of bank read bits
// jump mask and BTB masking for ways A and B
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ghtSlotFilter (
    input  logic [ghtPkg::bankBits-1:0] slotBank [ghtPkg::numSlots],
    input  logic [3:0]                  jumpMaskReg,
    input  logic [ghtPkg::numBanks-1:0] readBits,
    input  logic [3:0]                  btbPredA,
    input  logic [3:0]                  btbPredB,
    output logic [3:0]                  predA,
    output logic [3:0]                  predB
);

    import ghtPkg::*;

    logic [numSlots-1:0] slotBit;

    always_comb begin
        for (int k = 0; k < numSlots; k++) begin
            slotBit[k] = readBits[slotBank[k]];
        end
    end

    // a BTB hit on a way overrides the table for that way only
    assign predA = jumpMaskReg & ~btbPredA & slotBit;
    assign predB = jumpMaskReg & ~btbPredB & slotBit;

endmodule

`default_nettype wire

/* verilog/ghtPredictor.sv */
////////////////////////////////////////////////////////////
// global-history direction table top level
// lookup, eight banks, write arbiter and slot filter
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ghtPredictor (
    input  logic              clk,
    input  logic              rst,
    input  logic              readEn,
    input  logic [15:0]       ipBits,
    input  logic [15:0]       history,
    input  logic [3:0]        jumpMask,
    input  logic [3:0]        btbPredA,
    input  logic [3:0]        btbPredB,
    input  ghtPkg::ghtWrite_t write0,
    input  ghtPkg::ghtWrite_t write1,
    output logic [3:0]        predA,
    output logic [3:0]        predB
);

    import ghtPkg::*;

    ghtBankRead_t        bankRead [numBanks];
    ghtBankWrite_t       bankWrite [numBanks];
    logic [numBanks-1:0] writeTaken;
    logic [numBanks-1:0] readBits;
    logic [bankBits-1:0] slotBank [numSlots];
    logic [3:0]          jumpMaskReg;

    ghtLookup i_lookup (
        .clk        (clk),
        .rst        (rst),
        .readEn     (readEn),
        .ipBits     (ipBits),
        .history    (history),
        .jumpMask   (jumpMask),
        .bankRead   (bankRead),
        .slotBank   (slotBank),
        .jumpMaskReg(jumpMaskReg)
    );

    for (genvar b = 0; b < numBanks; b++) begin : g_bank
        ghtBank i_bank (
            .clk       (clk),
            .bankWrite (bankWrite[b]),
            .writeTaken(writeTaken[b]),
            .bankRead  (bankRead[b]),
            .readBit   (readBits[b])
        );
    end

    ghtWriteArbiter i_arbiter (
        .clk       (clk),
        .rst       (rst),
        .write0    (write0),
        .write1    (write1),
        .bankWrite (bankWrite),
        .writeTaken(writeTaken)
    );

    ghtSlotFilter i_filter (
        .slotBank   (slotBank),
        .jumpMaskReg(jumpMaskReg),
        .readBits   (readBits),
        .btbPredA   (btbPredA),
        .btbPredB   (btbPredB),
        .predA      (predA),
        .predB      (predB)
    );

endmodule

`default_nettype wire

/* tb/ghtPredictor_checker.sv */
////////////////////////////////////////////////////////////
// assertions on the write arbiter: clear sequencing
// and deferral register use
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ghtPredictor_checker (
    input logic                        clk,
    input logic                        rst,
    input ghtPkg::ghtWrite_t           deferred,
    input logic                        v0,
    input logic                        v1,
    input logic [ghtPkg::bankBits-1:0] bank0,
    input logic [ghtPkg::bankBits-1:0] bank1,
    input logic [ghtPkg::bankBits-1:0] bankD,
    input ghtPkg::ghtBankWrite_t       bankWrite [ghtPkg::numBanks]
);

    import ghtPkg::*;

    int                  failCount = 0;
    logic                clearOnly;
    logic                anyClear;
    logic [5:0]          clearEdge;
    logic [numBanks-1:0] pairBanks;
    logic [numBanks-1:0] pairBanksPrev;

    // edges seen since reset release, saturating once all rows are done
    always_ff @(posedge clk) begin
        if (rst) begin
            clearEdge <= '0;
        end else if (clearEdge != 6'(numRows)) begin
            clearEdge <= clearEdge + 1'b1;
        end
    end

    always_comb begin
        clearOnly = 1'b1;
        anyClear  = 1'b0;
        for (int b = 0; b < numBanks; b++) begin
            if (!(bankWrite[b].en && bankWrite[b].clear
                  && bankWrite[b].row == clearEdge[4:0])) begin
                clearOnly = 1'b0;
            end
            if (bankWrite[b].clear) begin
                anyClear = 1'b1;
            end
        end
    end

    // banks asked for by two or more sources at this edge
    always_comb begin
        for (int b = 0; b < numBanks; b++) begin
            pairBanks[b] = (int'(v0 && bank0 == bankBits'(b))
                            + int'(v1 && bank1 == bankBits'(b))
                            + int'(deferred.valid && bankD == bankBits'(b))) >= 2;
        end
    end

    always_ff @(posedge clk) begin
        pairBanksPrev <= pairBanks;
    end

    // every bank takes only the row clear while clearing
    clearWritesOnly: assert property (@(posedge clk) disable iff (rst)
                                      clearEdge < 6'(numRows) |-> clearOnly)
        else begin
            failCount = failCount + 1;
            $error("bank write other than the row clear during the clear sequence");
        end

    noStrayClear: assert property (@(posedge clk) disable iff (rst)
                                   clearEdge == 6'(numRows) |-> !anyClear)
        else begin
            failCount = failCount + 1;
            $error("row clear issued outside the clear sequence");
        end

    // a deferred entry sits in a bank that two sources wanted one edge earlier
    deferOnConflict: assert property (@(posedge clk) disable iff (rst)
                                      deferred.valid |-> pairBanksPrev[bankD])
        else begin
            failCount = failCount + 1;
            $error("deferral register loaded without a bank conflict");
        end

endmodule

bind ghtWriteArbiter ghtPredictor_checker i_checker (
    .clk      (clk),
    .rst      (rst),
    .deferred (deferred),
    .v0       (v0),
    .v1       (v1),
    .bank0    (bank0),
    .bank1    (bank1),
    .bankD    (bankD),
    .bankWrite(bankWrite)
);

`default_nettype wire

/* tb/ghtModel.svh */
////////////////////////////////////////////////////////////
// testbench reference model: flat direction table, write
// arbitration with deferral and loss, slot prediction
////////////////////////////////////////////////////////////

`ifndef GHT_MODEL_SVH
`define GHT_MODEL_SVH

// table addressed by the flat index word
logic        modelTable [65536];
logic [15:0] modelIp;
logic [15:0] modelHist;
logic [3:0]  modelJm;
ghtWrite_t   modelDef;
int          clearLeft;

function automatic logic [2:0] bankNum(input logic [15:0] idx);
    return {idx[7:6], idx[0]};
endfunction

// slot k uses the history shifted by the jump slots below it
function automatic logic [15:0] slotIndex(input logic [15:0] ip, input logic [15:0] hist,
                                          input logic [3:0] jm, input int k);
    logic [15:0] base;
    logic [7:0]  sel;
    int          below;
    base  = ip ^ hist;
    below = 0;
    for (int i = 0; i < k; i++) begin
        below = below + int'(jm[i]);
    end
    sel = ip[15:8] ^ (hist[15:8] << below);
    return {sel, base[7:6] ^ 2'(k), base[5:1], base[0]};
endfunction

// returns {predA, predB}
function automatic logic [7:0] predictSlots(input logic [15:0] ip, input logic [15:0] hist,
                                            input logic [3:0] jm, input logic [3:0] btbA,
                                            input logic [3:0] btbB);
    logic [3:0] a;
    logic [3:0] b;
    logic       entry;
    for (int k = 0; k < 4; k++) begin
        entry = modelTable[slotIndex(ip, hist, jm, k)];
        a[k]  = (jm[k] && !btbA[k]) ? entry : 1'b0;
        b[k]  = (jm[k] && !btbB[k]) ? entry : 1'b0;
    end
    return {a, b};
endfunction

task automatic resetModel();
    for (int i = 0; i < 65536; i++) begin
        modelTable[i] = 1'b0;
    end
    modelDef.valid = 1'b0;
    modelJm        = '0;
    clearLeft      = numRows;
endtask

// one clock edge of training writes
task automatic applyWrites(input ghtWrite_t w0, input ghtWrite_t w1);
    logic v0;
    logic v1;
    logic hit0;
    logic hit1;
    v0   = w0.valid && clearLeft == 0;
    v1   = w1.valid && clearLeft == 0;
    hit0 = v0 && modelDef.valid && bankNum(w0.index.word) == bankNum(modelDef.index.word);
    hit1 = v1 && ((modelDef.valid && bankNum(w1.index.word) == bankNum(modelDef.index.word))
                  || (v0 && bankNum(w1.index.word) == bankNum(w0.index.word)));
    if (modelDef.valid) begin
        modelTable[modelDef.index.word] = modelDef.taken;
    end
    if (v0 && !hit0) begin
        modelTable[w0.index.word] = w0.taken;
    end
    if (v1 && !hit1) begin
        modelTable[w1.index.word] = w1.taken;
    end
    // write1 gets the deferral slot first, so write0 is lost when both collide
    if (hit1) begin
        modelDef = w1;
    end else if (hit0) begin
        modelDef = w0;
    end else begin
        modelDef.valid = 1'b0;
    end
    if (clearLeft > 0) begin
        clearLeft = clearLeft - 1;
    end
endtask

`endif

/* tb/ghtPredictorTb.sv */
////////////////////////////////////////////////////////////
// testbench for the direction table top level
// stimulus on the falling edge, model compare, timeout
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ghtPredictorTb;

    import ghtPkg::*;

    localparam int resetCycles = 3;
    localparam int clearWait   = 34;
    localparam int numSingle   = 16;
    localparam int numConflict = 24;
    localparam int numClearWr  = 30;
    localparam int stimCycles  = 2 * (resetCycles + clearWait) + 8 + 2 * numSingle + 15 + 12
                                 + 3 * numConflict + 3 * numClearWr + 10;
    localparam int maxCycles   = stimCycles + 100;

    logic        clk = 1'b0;
    logic        rst;
    logic        readEn;
    logic [15:0] ipBits;
    logic [15:0] history;
    logic [3:0]  jumpMask;
    logic [3:0]  btbPredA;
    logic [3:0]  btbPredB;
    ghtWrite_t   write0;
    ghtWrite_t   write1;
    logic [3:0]  predA;
    logic [3:0]  predB;

    int          seed;
    int          errorCount    = 0;
    int          checkCount    = 0;
    int          cycleCount    = 0;
    logic        lookupPending = 1'b0;
    logic [15:0] writtenQ [$];

    `include "ghtModel.svh"

    ghtPredictor i_dut (
        .clk     (clk),
        .rst     (rst),
        .readEn  (readEn),
        .ipBits  (ipBits),
        .history (history),
        .jumpMask(jumpMask),
        .btbPredA(btbPredA),
        .btbPredB(btbPredB),
        .write0  (write0),
        .write1  (write1),
        .predA   (predA),
        .predB   (predB)
    );

    always #20 clk = ~clk;

    task automatic checkValue(input string name, input logic [3:0] got, input logic [3:0] exp);
        checkCount = checkCount + 1;
        if (got !== exp) begin
            errorCount = errorCount + 1;
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // model follows the DUT edge by edge
    always @(posedge clk) begin
        if (rst) begin
            resetModel();
        end else begin
            applyWrites(write0, write1);
        end
        if (readEn) begin
            modelIp   = ipBits;
            modelHist = history;
        end
        if (readEn && !rst) begin
            modelJm = jumpMask;
        end
        lookupPending = readEn && !rst;
    end

    always begin
        logic [7:0] expected;
        @(posedge clk);
        #10;
        if (lookupPending) begin
            expected = predictSlots(modelIp, modelHist, modelJm, btbPredA, btbPredB);
            checkValue("predA", predA, expected[7:4]);
            checkValue("predB", predB, expected[3:0]);
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > maxCycles) begin
            $display("timeout: stimulus still running after %0d cycles", cycleCount);
            $display("checks %0d, mismatches %0d", checkCount, errorCount);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic idleCycle();
        @(negedge clk);
        readEn = 1'b0;
        write0 = '0;
        write1 = '0;
    endtask

    task automatic issueLookup(input logic [15:0] ip, input logic [15:0] hist,
                               input logic [3:0] jm, input logic [3:0] btbA,
                               input logic [3:0] btbB);
        @(negedge clk);
        readEn   = 1'b1;
        ipBits   = ip;
        history  = hist;
        jumpMask = jm;
        btbPredA = btbA;
        btbPredB = btbB;
        write0   = '0;
        write1   = '0;
    endtask

    task automatic presentWrites(input ghtWrite_t w0, input ghtWrite_t w1);
        @(negedge clk);
        readEn = 1'b0;
        write0 = w0;
        write1 = w1;
    endtask

    task automatic makeWrite(input logic [2:0] bank, input logic taken, output ghtWrite_t w);
        w.valid               = 1'b1;
        w.index.word          = 16'($random(seed));
        w.index.fields.bankHi = bank[2:1];
        w.index.fields.bankLo = bank[0];
        w.taken               = taken;
    endtask

    task automatic applyReset();
        @(negedge clk);
        rst    = 1'b1;
        readEn = 1'b0;
        write0 = '0;
        write1 = '0;
        repeat (resetCycles) @(negedge clk);
        rst = 1'b0;
    endtask

    // read back every queued index on slot 0, where the slot index is ipBits ^ history
    task automatic readBackQueue();
        logic [15:0] idx;
        logic [15:0] hist;
        while (writtenQ.size() > 0) begin
            idx  = writtenQ.pop_front();
            hist = 16'($random(seed));
            issueLookup(idx ^ hist, hist, 4'b0001, 4'b0000, 4'b0000);
        end
    endtask

    initial begin
        logic [15:0] ip;
        logic [15:0] hist;
        logic [3:0]  jm;
        logic [3:0]  patterns [3];
        ghtWrite_t   w0;
        ghtWrite_t   w1;
        seed        = 32'hb6d;
        patterns[0] = 4'b1111;
        patterns[1] = 4'b1010;
        patterns[2] = 4'b0110;
        rst      = 1'b1;
        readEn   = 1'b0;
        ipBits   = '0;
        history  = '0;
        jumpMask = '0;
        btbPredA = '0;
        btbPredB = '0;
        write0   = '0;
        write1   = '0;
        repeat (resetCycles) @(negedge clk);
        rst = 1'b0;
        repeat (clearWait) idleCycle();

        // cleared table reads not taken everywhere
        for (int n = 0; n < 8; n++) begin
            issueLookup(16'($random(seed)), 16'($random(seed)), 4'b1111, 4'b0000, 4'b0000);
        end

        for (int n = 0; n < numSingle; n++) begin
            hist = 16'($random(seed));
            makeWrite(3'($random(seed)), 1'($random(seed)), w0);
            presentWrites(w0, '0);
            issueLookup(w0.index.word ^ hist, hist, 4'b0001, 4'b0000, 4'b0000);
        end

        // per-slot indexes under shifted history
        for (int p = 0; p < 3; p++) begin
            ip   = 16'($random(seed));
            hist = 16'($random(seed));
            jm   = patterns[p];
            for (int k = 0; k < numSlots; k++) begin
                w0 = '{valid: 1'b1, index: slotIndex(ip, hist, jm, k), taken: 1'b1};
                presentWrites(w0, '0);
            end
            issueLookup(ip, hist, jm, 4'b0000, 4'b0000);
        end

        // jump and BTB masking on a fully taken lookup
        ip   = 16'($random(seed));
        hist = 16'($random(seed));
        for (int k = 0; k < numSlots; k++) begin
            w0 = '{valid: 1'b1, index: slotIndex(ip, hist, 4'b1111, k), taken: 1'b1};
            presentWrites(w0, '0);
        end
        for (int n = 0; n < 8; n++) begin
            jm = (n < 4) ? 4'b1111 : 4'($random(seed));
            issueLookup(ip, hist, jm, 4'($random(seed)), 4'($random(seed)));
        end

        // two banks for three sources forces pair and triple conflicts
        for (int n = 0; n < numConflict; n++) begin
            makeWrite(($random(seed) & 1) ? 3'd3 : 3'd5, 1'($random(seed)), w0);
            makeWrite(($random(seed) & 1) ? 3'd3 : 3'd5, 1'($random(seed)), w1);
            w0.valid = ($random(seed) & 3) != 0;
            w1.valid = ($random(seed) & 3) != 0;
            if (w0.valid) begin
                writtenQ.push_back(w0.index.word);
            end
            if (w1.valid) begin
                writtenQ.push_back(w1.index.word);
            end
            presentWrites(w0, w1);
        end
        repeat (2) idleCycle();
        readBackQueue();

        // taken writes while the clear sequence runs
        applyReset();
        for (int n = 0; n < numClearWr; n++) begin
            makeWrite(3'($random(seed)), 1'b1, w0);
            makeWrite(3'($random(seed)), 1'b1, w1);
            writtenQ.push_back(w0.index.word);
            writtenQ.push_back(w1.index.word);
            presentWrites(w0, w1);
        end
        repeat (4) idleCycle();
        readBackQueue();
        repeat (2) idleCycle();

        errorCount = errorCount + i_dut.i_arbiter.i_checker.failCount;
        $display("checks %0d, mismatches %0d, assertion failures %0d", checkCount,
                 errorCount - i_dut.i_arbiter.i_checker.failCount,
                 i_dut.i_arbiter.i_checker.failCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+tb
verilog/ghtPkg.sv
verilog/ghtLookup.sv
verilog/ghtBank.sv
verilog/ghtWriteArbiter.sv
verilog/ghtSlotFilter.sv
verilog/ghtPredictor.sv
tb/ghtPredictor_checker.sv
tb/ghtPredictorTb.sv
